// File: test/arch_test_golden.txt
# Columns (hex): R addr expected | W addr data sel | T rdst data ledr ledg | J addr | B
# R core read, W core write, T retire then key step, J redirect, B boot image readback
R 00000004 00100093
B
W 00000040 11223344 f
R 00000040 11223344
W 00000040 aabbccdd 5
R 00000040 11bb33dd
W 00000040 deadbeef 8
R 00000040 debb33dd
W 00000044 0badf00d f
W 00000044 55667788 6
R 00000044 0b66770d
W 00000044 12345678 2
R 00000044 0b66560d
T 05 89abcdef 20000 05
J 0001abcd
T 1f 01234567 2abcd 1f

// File: test/boot_image.hex
// One 32-bit word per line, written to SRAM byte address 4*i
00000013
00100093
00200113
002081b3
00302023
00002203
0000006f
deadc0de

// File: flist.f
hdl/board_pkg.sv
hdl/wb_pkg.sv
hdl/key_edge_detector.sv
hdl/seg7_display.sv
hdl/step_ctrl.sv
hdl/boot_loader.sv
hdl/wb_arbiter.sv
hdl/sram_wb.sv
hdl/arch_test_top.sv
test/sram_model.sv
test/arch_test_tb.sv

// File: test/arch_test_tb.sv
/* Plays the core against the harness, driven by test/arch_test_golden.txt.
   Run from the project root; boot words are compared with test/boot_image.hex. */
`timescale 1ns/1ps

module arch_test_tb import wb_pkg::*, board_pkg::*; ();

    localparam int ACK_TIMEOUT  = 200;
    localparam int BOOT_TIMEOUT = 400;
    localparam int KEY_TIMEOUT  = 12;

    logic        clk = 1'b0;
    logic        n_rst;
    logic        key_n;
    logic        core_cyc;
    logic        core_stb;
    logic        core_we;
    wb_sel_t     core_sel;
    wb_addr_t    core_addr;
    wb_data_t    core_wdata;
    wb_data_t    core_rdata;
    logic        core_ack;
    logic        core_en;
    logic        retire_en;
    reg_idx_t    retire_rdst;
    wb_data_t    retire_data;
    logic        redirect;
    wb_addr_t    redirect_addr;
    logic [17:0] ledr;
    logic [7:0]  ledg;
    seg7_t       hex [HEX_DIGITS];
    logic        sram_ce_n;
    logic        sram_oe_n;
    logic        sram_we_n;
    logic        sram_lb_n;
    logic        sram_ub_n;
    sram_addr_t  sram_addr;
    wire sram_data_t sram_dq;

    wb_data_t    boot_image [BOOT_WORDS];
    logic [31:0] lcg_state = 32'h3696_fbb3;
    logic [7:0]  last_ledg = 8'h00;

    always #2 clk = ~clk;

    arch_test_top arch_test_top_i (
        .clk(clk), .n_rst(n_rst), .i_key_n(key_n),
        .i_core_wb_cyc(core_cyc), .i_core_wb_stb(core_stb), .i_core_wb_we(core_we),
        .i_core_wb_sel(core_sel), .i_core_wb_addr(core_addr), .i_core_wb_data(core_wdata),
        .o_core_wb_data(core_rdata), .o_core_wb_ack(core_ack), .o_core_en(core_en),
        .i_retire_en(retire_en), .i_retire_rdst(retire_rdst), .i_retire_data(retire_data),
        .i_redirect(redirect), .i_redirect_addr(redirect_addr),
        .o_ledr(ledr), .o_ledg(ledg), .o_hex(hex),
        .o_sram_ce_n(sram_ce_n), .o_sram_oe_n(sram_oe_n), .o_sram_we_n(sram_we_n),
        .o_sram_lb_n(sram_lb_n), .o_sram_ub_n(sram_ub_n), .o_sram_addr(sram_addr),
        .io_sram_dq(sram_dq)
    );

    sram_model sram_i (
        .i_ce_n(sram_ce_n), .i_oe_n(sram_oe_n), .i_we_n(sram_we_n), .i_lb_n(sram_lb_n),
        .i_ub_n(sram_ub_n), .i_addr(sram_addr), .io_dq(sram_dq)
    );

    // Standard hex font, active-high gfedcba, inverted for the board
    function automatic seg7_t seg_font(input logic [3:0] nib);
        logic [6:0] lit;
        case (nib)
            4'h0: lit = 7'h3f;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5b;
            4'h3: lit = 7'h4f;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6d;
            4'h6: lit = 7'h7d;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7f;
            4'h9: lit = 7'h6f;
            4'ha: lit = 7'h77;
            4'hb: lit = 7'h7c;
            4'hc: lit = 7'h39;
            4'hd: lit = 7'h5e;
            4'he: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    function automatic int random_gap();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[17:16]);       // 0 to 3 idle cycles
    endfunction

    task automatic report_failure();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input wb_data_t exp, input wb_data_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_digit(input string name, input seg7_t exp, input seg7_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_leds(input logic [17:0] exp_r, input logic [7:0] exp_g);
        if (ledr !== exp_r) begin
            $display("** Error at %0t: o_ledr expected %h, got %h", $time, exp_r, ledr);
            report_failure();
        end
        if (ledg !== exp_g) begin
            $display("** Error at %0t: o_ledg expected %h, got %h", $time, exp_g, ledg);
            report_failure();
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
            report_failure();
        end
    endtask

    task automatic advance_cycle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic wait_core_en(input int limit);
        int cycles;
        cycles = 0;
        while (core_en !== 1'b1) begin
            if (cycles == limit) begin
                $display("o_core_en did not rise within %0d cycles", limit);
                report_failure();
            end
            advance_cycle();
            cycles++;
        end
    endtask

    // Boot loader owns the bus once the SRAM is first selected
    task automatic wait_boot_start();
        int cycles;
        cycles = 0;
        while (sram_ce_n !== 1'b0) begin
            if (cycles == 20) begin
                $display("SRAM was not accessed after reset");
                report_failure();
            end
            advance_cycle();
            cycles++;
        end
    endtask

    task automatic core_access(input logic we, input wb_sel_t sel, input wb_addr_t addr,
                               input wb_data_t wdata, output wb_data_t rdata);
        int cycles;
        cycles     = 0;
        core_cyc   = 1'b1;
        core_stb   = 1'b1;
        core_we    = we;
        core_sel   = sel;
        core_addr  = addr;
        core_wdata = wdata;
        while (core_ack !== 1'b1) begin
            if (cycles == ACK_TIMEOUT) begin
                $display("no ack on the core port for address %h", addr);
                report_failure();
            end
            advance_cycle();
            cycles++;
        end
        rdata = core_rdata;
        check_level("o_ledr[17] at core ack", 1'b1, ledr[17]);   // Core waits out boot
        advance_cycle();
        core_cyc = 1'b0;
        core_stb = 1'b0;
        core_we  = 1'b0;
        advance_cycle();
    endtask

    task automatic check_boot_image();
        wb_data_t rdata;
        int       cycles;
        cycles = 0;
        while (ledr[17] !== 1'b1) begin
            if (cycles == BOOT_TIMEOUT) begin
                $display("boot did not finish within %0d cycles", BOOT_TIMEOUT);
                report_failure();
            end
            advance_cycle();
            cycles++;
        end
        for (int i = 0; i < BOOT_WORDS; i++) begin
            core_access(1'b0, 4'hf, SRAM_BASE_ADDR + 32'(4 * i), '0, rdata);
            check_word($sformatf("boot word %0d", i), boot_image[i], rdata);
        end
    endtask

    task automatic retire_and_step(input reg_idx_t rdst, input wb_data_t data,
                                   input logic [17:0] exp_r, input logic [7:0] exp_g);
        wait_core_en(BOOT_TIMEOUT);
        retire_en   = 1'b1;
        retire_rdst = rdst;
        retire_data = data;
        advance_cycle();
        retire_en = 1'b0;
        check_level("o_core_en after retire", 1'b0, core_en);
        check_leds(exp_r, exp_g);
        advance_cycle();
        for (int k = 0; k < HEX_DIGITS; k++) begin
            check_digit($sformatf("o_hex[%0d]", k), seg_font(data[4*k +: 4]), hex[k]);
        end
        repeat (4) begin
            advance_cycle();
            check_level("o_core_en while halted", 1'b0, core_en);
        end
        key_n = 1'b0;
        wait_core_en(KEY_TIMEOUT);
        key_n     = 1'b1;
        last_ledg = exp_g;
    endtask

    task automatic send_redirect(input wb_addr_t addr);
        redirect      = 1'b1;
        redirect_addr = addr;
        advance_cycle();
        redirect = 1'b0;
        check_leds({1'b1, 1'b1, addr[15:0]}, last_ledg);
    endtask

    task automatic run_golden_file();
        int          fd;
        int          c;
        logic [7:0]  cmd;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        wb_data_t    rdata;
        fd = $fopen("test/arch_test_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/arch_test_golden.txt");
            report_failure();
        end
        while ($fscanf(fd, " %c", cmd) == 1) begin
            if (cmd == "#") begin
                c = $fgetc(fd);
                while (c != "\n" && c != -1) c = $fgetc(fd);
                continue;
            end
            case (cmd)
                "R": begin
                    c = $fscanf(fd, "%h %h", f1, f2);
                    core_access(1'b0, 4'hf, f1, '0, rdata);
                    check_word($sformatf("o_core_wb_data @%h", f1), f2, rdata);
                end
                "W": begin
                    c = $fscanf(fd, "%h %h %h", f1, f2, f3);
                    core_access(1'b1, wb_sel_t'(f3), f1, f2, rdata);
                end
                "T": begin
                    c = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
                    retire_and_step(reg_idx_t'(f1), f2, f3[17:0], f4[7:0]);
                end
                "J": begin
                    c = $fscanf(fd, "%h", f1);
                    send_redirect(f1);
                end
                "B": check_boot_image();
                default: begin
                    $display("unknown command '%c' in the golden file", cmd);
                    report_failure();
                end
            endcase
            repeat (random_gap()) advance_cycle();
        end
        $fclose(fd);
    endtask

    initial begin
        n_rst         = 1'b0;
        key_n         = 1'b1;
        core_cyc      = 1'b0;
        core_stb      = 1'b0;
        core_we       = 1'b0;
        core_sel      = '0;
        core_addr     = '0;
        core_wdata    = '0;
        retire_en     = 1'b0;
        retire_rdst   = '0;
        retire_data   = '0;
        redirect      = 1'b0;
        redirect_addr = '0;
        $readmemh("test/boot_image.hex", boot_image);
        repeat (3) @(posedge clk);
        #0.5;
        check_level("o_sram_ce_n in reset", 1'b1, sram_ce_n);
        check_level("o_sram_we_n in reset", 1'b1, sram_we_n);
        check_level("o_sram_oe_n in reset", 1'b1, sram_oe_n);
        check_level("io_sram_dq released", 1'b1, sram_dq === 16'hzzzz);
        check_level("o_core_wb_ack in reset", 1'b0, core_ack);
        check_level("o_core_en in reset", 1'b0, core_en);
        check_leds(18'h0, 8'h0);
        for (int k = 0; k < HEX_DIGITS; k++) begin
            check_digit($sformatf("o_hex[%0d] in reset", k), 7'h7f, hex[k]);
        end
        n_rst = 1'b1;
        wait_boot_start();
        run_golden_file();
        $display("all tests passed");
        $finish;
    end

endmodule

// File: test/sram_model.sv
/* Behavioral 16-bit async SRAM. A write is taken 1 ns into the WE_N low pulse.
   Half-words that were never written read back a fill pattern derived from the full address. */
`timescale 1ns/1ps

module sram_model import wb_pkg::*, board_pkg::*; (
    input  logic       i_ce_n,
    input  logic       i_oe_n,
    input  logic       i_we_n,
    input  logic       i_lb_n,
    input  logic       i_ub_n,
    input  sram_addr_t i_addr,
    inout  wire sram_data_t io_dq
);

    sram_data_t mem [2**SRAM_ADDR_WIDTH];
    sram_data_t rd_word;
    logic       reading;

    initial begin
        for (int a = 0; a < 2**SRAM_ADDR_WIDTH; a++) begin
            mem[a] = 16'(a) ^ 16'(a >> 8) ^ 16'h5a3c;
        end
    end

    // Inputs are settled well inside the strobe cycle
    always @(negedge i_we_n) begin
        #1;
        if (!i_we_n && !i_ce_n) begin
            if (!i_lb_n) mem[i_addr][7:0] = io_dq[7:0];
            if (!i_ub_n) mem[i_addr][15:8] = io_dq[15:8];
        end
    end

    assign reading      = !i_ce_n && !i_oe_n && i_we_n;
    assign rd_word      = mem[i_addr];
    assign io_dq[7:0]   = (reading && !i_lb_n) ? rd_word[7:0] : 8'hzz;
    assign io_dq[15:8]  = (reading && !i_ub_n) ? rd_word[15:8] : 8'hzz;

endmodule

// File: hdl/arch_test_top.sv
/* Board test harness around an external core: boot copy into SRAM, shared SRAM bridge, single-step.
   The core attaches through the i_core_wb_* port and is throttled by o_core_en. */
`timescale 1ns/1ps

module arch_test_top import wb_pkg::*, board_pkg::*; (
    input  logic        clk,
    input  logic        n_rst,
    input  logic        i_key_n,

    input  logic        i_core_wb_cyc,
    input  logic        i_core_wb_stb,
    input  logic        i_core_wb_we,
    input  wb_sel_t     i_core_wb_sel,
    input  wb_addr_t    i_core_wb_addr,
    input  wb_data_t    i_core_wb_data,
    output wb_data_t    o_core_wb_data,
    output logic        o_core_wb_ack,

    output logic        o_core_en,
    input  logic        i_retire_en,
    input  reg_idx_t    i_retire_rdst,
    input  wb_data_t    i_retire_data,
    input  logic        i_redirect,
    input  wb_addr_t    i_redirect_addr,

    output logic [17:0] o_ledr,
    output logic [7:0]  o_ledg,
    output seg7_t       o_hex [HEX_DIGITS],

    output logic        o_sram_ce_n,
    output logic        o_sram_oe_n,
    output logic        o_sram_we_n,
    output logic        o_sram_lb_n,
    output logic        o_sram_ub_n,
    output sram_addr_t  o_sram_addr,
    inout  wire sram_data_t io_sram_dq
);

    logic     key_pulse;
    logic     boot_done;
    wb_data_t retire_data;

    // Boot loader master, write only
    logic     boot_cyc, boot_stb, boot_we, boot_ack;
    wb_sel_t  boot_sel;
    wb_addr_t boot_addr;
    wb_data_t boot_wdata;

    // Arbitrated bus into the SRAM bridge
    logic     s_cyc, s_stb, s_we, s_ack;
    wb_sel_t  s_sel;
    wb_addr_t s_addr;
    wb_data_t s_wdata, s_rdata;

    key_edge_detector key_edge_detector_inst (
        .clk(clk), .n_rst(n_rst), .i_key_n(i_key_n), .o_pulse(key_pulse)
    );

    step_ctrl step_ctrl_inst (
        .clk(clk), .n_rst(n_rst), .i_boot_done(boot_done), .i_key_pulse(key_pulse),
        .i_retire_en(i_retire_en), .i_retire_rdst(i_retire_rdst),
        .i_retire_data(i_retire_data), .i_redirect(i_redirect),
        .i_redirect_addr(i_redirect_addr), .o_core_en(o_core_en),
        .o_ledr(o_ledr), .o_ledg(o_ledg), .o_retire_data(retire_data)
    );

    seg7_display seg7_display_inst (
        .clk(clk), .n_rst(n_rst), .i_value(retire_data), .o_hex(o_hex)
    );

    boot_loader boot_loader_inst (
        .clk(clk), .n_rst(n_rst), .o_wb_cyc(boot_cyc), .o_wb_stb(boot_stb),
        .o_wb_we(boot_we), .o_wb_sel(boot_sel), .o_wb_addr(boot_addr),
        .o_wb_data(boot_wdata), .i_wb_ack(boot_ack), .o_boot_done(boot_done)
    );

    wb_arbiter wb_arbiter_inst (
        .clk(clk), .n_rst(n_rst),
        .i_m0_cyc(boot_cyc), .i_m0_stb(boot_stb), .i_m0_we(boot_we), .i_m0_sel(boot_sel),
        .i_m0_addr(boot_addr), .i_m0_data(boot_wdata), .o_m0_data(),
        .o_m0_ack(boot_ack),
        .i_m1_cyc(i_core_wb_cyc), .i_m1_stb(i_core_wb_stb), .i_m1_we(i_core_wb_we),
        .i_m1_sel(i_core_wb_sel), .i_m1_addr(i_core_wb_addr), .i_m1_data(i_core_wb_data),
        .o_m1_data(o_core_wb_data), .o_m1_ack(o_core_wb_ack),
        .o_s_cyc(s_cyc), .o_s_stb(s_stb), .o_s_we(s_we), .o_s_sel(s_sel),
        .o_s_addr(s_addr), .o_s_data(s_wdata), .i_s_data(s_rdata), .i_s_ack(s_ack)
    );

    sram_wb sram_wb_inst (
        .clk(clk), .n_rst(n_rst), .i_wb_cyc(s_cyc), .i_wb_stb(s_stb), .i_wb_we(s_we),
        .i_wb_sel(s_sel), .i_wb_addr(s_addr), .i_wb_data(s_wdata), .o_wb_data(s_rdata),
        .o_wb_ack(s_ack), .o_sram_ce_n(o_sram_ce_n), .o_sram_oe_n(o_sram_oe_n),
        .o_sram_we_n(o_sram_we_n), .o_sram_lb_n(o_sram_lb_n), .o_sram_ub_n(o_sram_ub_n),
        .o_sram_addr(o_sram_addr), .io_sram_dq(io_sram_dq)
    );

endmodule

// File: hdl/sram_wb.sv
/* Wishbone slave for a 16-bit async SRAM, two half-word phases per access, ack 5 cycles after request.
   Master must hold all signals until ack and drop cyc the cycle after; classic cycles only. */
`timescale 1ns/1ps

module sram_wb import wb_pkg::*, board_pkg::*; (
    input  logic       clk,
    input  logic       n_rst,
    input  logic       i_wb_cyc,
    input  logic       i_wb_stb,
    input  logic       i_wb_we,
    input  wb_sel_t    i_wb_sel,
    input  wb_addr_t   i_wb_addr,
    input  wb_data_t   i_wb_data,
    output wb_data_t   o_wb_data,
    output logic       o_wb_ack,
    output logic       o_sram_ce_n,
    output logic       o_sram_oe_n,
    output logic       o_sram_we_n,
    output logic       o_sram_lb_n,
    output logic       o_sram_ub_n,
    output sram_addr_t o_sram_addr,
    inout  wire sram_data_t io_sram_dq
);

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_LO_SETUP,
        PH_LO_STB,
        PH_HI_SETUP,
        PH_HI_STB,
        PH_ACK
    } phase_t;

    phase_t     phase;
    logic       active;
    logic       hi_half;
    logic       strobe;
    wb_addr_t   offset;
    sram_addr_t half_addr;
    sram_data_t rd_lo;
    sram_data_t rd_hi;
    sram_data_t dq_out;
    logic       dq_drive;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            phase <= PH_IDLE;
        end else begin
            case (phase)
                PH_IDLE:     if (i_wb_cyc && i_wb_stb) phase <= PH_LO_SETUP;
                PH_LO_SETUP: phase <= PH_LO_STB;
                PH_LO_STB:   phase <= PH_HI_SETUP;
                PH_HI_SETUP: phase <= PH_HI_STB;
                PH_HI_STB:   phase <= PH_ACK;
                default:     phase <= PH_IDLE;
            endcase
        end
    end

    // Sample read data at the end of each strobe cycle
    always_ff @(posedge clk) begin
        if (phase == PH_LO_STB && !i_wb_we) begin
            rd_lo <= io_sram_dq;
        end
        if (phase == PH_HI_STB && !i_wb_we) begin
            rd_hi <= io_sram_dq;
        end
    end

    assign active  = phase inside {PH_LO_SETUP, PH_LO_STB, PH_HI_SETUP, PH_HI_STB};
    assign hi_half = phase inside {PH_HI_SETUP, PH_HI_STB};
    assign strobe  = phase inside {PH_LO_STB, PH_HI_STB};

    assign offset      = i_wb_addr - SRAM_BASE_ADDR;
    assign half_addr   = offset[SRAM_ADDR_WIDTH:1];     // Byte to half-word address
    assign o_sram_addr = half_addr + sram_addr_t'(hi_half);

    assign o_sram_ce_n = ~active;
    assign o_sram_oe_n = ~(active & ~i_wb_we);
    assign o_sram_we_n = ~(strobe & i_wb_we);
    assign o_sram_lb_n = ~(active & (hi_half ? i_wb_sel[2] : i_wb_sel[0]));
    assign o_sram_ub_n = ~(active & (hi_half ? i_wb_sel[3] : i_wb_sel[1]));

    assign dq_out     = hi_half ? i_wb_data[WB_DATA_WIDTH-1 -: SRAM_DATA_WIDTH]
                                : i_wb_data[SRAM_DATA_WIDTH-1:0];
    assign dq_drive   = strobe & i_wb_we;       // Bus released outside write strobes
    assign io_sram_dq = dq_drive ? dq_out : 'z;

    assign o_wb_data = {rd_hi, rd_lo};
    assign o_wb_ack  = (phase == PH_ACK);

    // Request held through both half-word phases
    a_req_held: assert property (@(posedge clk) disable iff (!n_rst)
        active |-> i_wb_cyc && i_wb_stb && $stable(i_wb_we) && $stable(i_wb_addr));

endmodule

// File: hdl/wb_arbiter.sv
/* Two-master Wishbone classic arbiter, master 0 wins when idle and both request.
   A grant holds until the owner drops cyc; the loser sees no ack and waits. */
`timescale 1ns/1ps

module wb_arbiter import wb_pkg::*; (
    input  logic     clk,
    input  logic     n_rst,

    input  logic     i_m0_cyc,
    input  logic     i_m0_stb,
    input  logic     i_m0_we,
    input  wb_sel_t  i_m0_sel,
    input  wb_addr_t i_m0_addr,
    input  wb_data_t i_m0_data,
    output wb_data_t o_m0_data,
    output logic     o_m0_ack,

    input  logic     i_m1_cyc,
    input  logic     i_m1_stb,
    input  logic     i_m1_we,
    input  wb_sel_t  i_m1_sel,
    input  wb_addr_t i_m1_addr,
    input  wb_data_t i_m1_data,
    output wb_data_t o_m1_data,
    output logic     o_m1_ack,

    output logic     o_s_cyc,
    output logic     o_s_stb,
    output logic     o_s_we,
    output wb_sel_t  o_s_sel,
    output wb_addr_t o_s_addr,
    output wb_data_t o_s_data,
    input  wb_data_t i_s_data,
    input  logic     i_s_ack
);

    logic grant_valid;
    logic grant_m1;                            // Owner when grant_valid

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            grant_valid <= 1'b0;
            grant_m1    <= 1'b0;
        end else if (!grant_valid) begin
            if (i_m0_cyc) begin
                grant_valid <= 1'b1;
                grant_m1    <= 1'b0;
            end else if (i_m1_cyc) begin
                grant_valid <= 1'b1;
                grant_m1    <= 1'b1;
            end
        end else if (grant_m1 ? !i_m1_cyc : !i_m0_cyc) begin
            grant_valid <= 1'b0;               // Owner finished its cycle
        end
    end

    assign o_s_cyc  = grant_valid & (grant_m1 ? i_m1_cyc : i_m0_cyc);
    assign o_s_stb  = grant_valid & (grant_m1 ? i_m1_stb : i_m0_stb);
    assign o_s_we   = grant_m1 ? i_m1_we   : i_m0_we;
    assign o_s_sel  = grant_m1 ? i_m1_sel  : i_m0_sel;
    assign o_s_addr = grant_m1 ? i_m1_addr : i_m0_addr;
    assign o_s_data = grant_m1 ? i_m1_data : i_m0_data;

    assign o_m0_data = i_s_data;
    assign o_m1_data = i_s_data;
    assign o_m0_ack  = i_s_ack & grant_valid & ~grant_m1;
    assign o_m1_ack  = i_s_ack & grant_valid & grant_m1;

    // Slave side request stays put until ack, whichever master owns it
    a_grant_stable: assert property (@(posedge clk) disable iff (!n_rst)
        o_s_cyc && !i_s_ack |=> o_s_cyc && $stable({o_s_we, o_s_sel, o_s_addr, o_s_data}));

endmodule

// File: hdl/boot_loader.sv
/* Copies BOOT_WORDS words from a hex-file ROM into SRAM with full-select Wishbone writes.
   Runs once per reset; o_boot_done stays high until the next reset. */
`timescale 1ns/1ps

module boot_loader import wb_pkg::*, board_pkg::*; (
    input  logic     clk,
    input  logic     n_rst,
    output logic     o_wb_cyc,
    output logic     o_wb_stb,
    output logic     o_wb_we,
    output wb_sel_t  o_wb_sel,
    output wb_addr_t o_wb_addr,
    output wb_data_t o_wb_data,
    input  logic     i_wb_ack,
    output logic     o_boot_done
);

    typedef enum logic [1:0] {ST_GAP, ST_REQ, ST_DONE} state_t;

    wb_data_t                        rom [BOOT_WORDS];
    state_t                          state;
    logic [$clog2(BOOT_WORDS)-1:0]   word_idx;

    initial begin
        $readmemh(BOOT_HEX_FILE, rom);
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state    <= ST_GAP;
            word_idx <= '0;
        end else begin
            case (state)
                ST_GAP: begin
                    state <= ST_REQ;               // One idle cycle between writes
                end
                ST_REQ: begin
                    if (i_wb_ack) begin
                        word_idx <= word_idx + 1'b1;
                        if (word_idx == BOOT_WORDS - 1) begin
                            state <= ST_DONE;
                        end else begin
                            state <= ST_GAP;
                        end
                    end
                end
                default: begin
                    state <= ST_DONE;
                end
            endcase
        end
    end

    assign o_wb_cyc    = (state == ST_REQ);
    assign o_wb_stb    = (state == ST_REQ);
    assign o_wb_we     = 1'b1;
    assign o_wb_sel    = '1;
    assign o_wb_addr   = SRAM_BASE_ADDR + {word_idx, 2'b00};
    assign o_wb_data   = rom[word_idx];
    assign o_boot_done = (state == ST_DONE);

endmodule

// File: hdl/step_ctrl.sv
/* Single-step control: the core runs only after boot and halts after each retire until a key press.
   Redirect LED holds until the next retire; only redirect address bits 15:0 are shown. */
`timescale 1ns/1ps

module step_ctrl import wb_pkg::*, board_pkg::*; (
    input  logic        clk,
    input  logic        n_rst,
    input  logic        i_boot_done,
    input  logic        i_key_pulse,
    input  logic        i_retire_en,
    input  reg_idx_t    i_retire_rdst,
    input  wb_data_t    i_retire_data,
    input  logic        i_redirect,
    input  wb_addr_t    i_redirect_addr,
    output logic        o_core_en,
    output logic [17:0] o_ledr,
    output logic [7:0]  o_ledg,
    output wb_data_t    o_retire_data
);

    typedef enum logic {ST_RUN, ST_HALT} state_t;

    state_t      state;
    reg_idx_t    retire_rdst_q;
    wb_data_t    retire_data_q;
    logic        redirect_q;
    logic [15:0] redirect_addr_q;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state           <= ST_RUN;
            retire_rdst_q   <= '0;
            retire_data_q   <= '0;
            redirect_q      <= 1'b0;
            redirect_addr_q <= '0;
        end else begin
            case (state)
                ST_RUN:  if (i_boot_done && i_retire_en) state <= ST_HALT;
                default: if (i_key_pulse) state <= ST_RUN;
            endcase
            if (i_retire_en) begin
                retire_rdst_q <= i_retire_rdst;
                retire_data_q <= i_retire_data;
            end
            if (i_redirect) begin
                redirect_q      <= 1'b1;       // Redirect wins over a same-cycle retire
                redirect_addr_q <= i_redirect_addr[15:0];
            end else if (i_retire_en) begin
                redirect_q <= 1'b0;
            end
        end
    end

    assign o_core_en     = i_boot_done && (state == ST_RUN);
    assign o_ledr        = {i_boot_done, redirect_q, redirect_addr_q};
    assign o_ledg        = 8'(retire_rdst_q);
    assign o_retire_data = retire_data_q;

    // Boot done is a level until reset, so the core never runs ahead of the boot copy
    a_core_en_gate: assert property (@(posedge clk) disable iff (!n_rst)
        i_boot_done |=> i_boot_done);

endmodule

// File: hdl/seg7_display.sv
/* Registered hex decode of a 32-bit value onto eight active-low digits, digit k = nibble k.
   Output lags the input by one cycle; all digits blank while in reset. */
`timescale 1ns/1ps

module seg7_display import wb_pkg::*, board_pkg::*; (
    input  logic     clk,
    input  logic     n_rst,
    input  wb_data_t i_value,
    output seg7_t    o_hex [HEX_DIGITS]
);

    function automatic seg7_t hex_font(input logic [3:0] nibble);
        seg7_t seg;
        case (nibble)
            4'h0: seg = 7'b1000000;
            4'h1: seg = 7'b1111001;
            4'h2: seg = 7'b0100100;
            4'h3: seg = 7'b0110000;
            4'h4: seg = 7'b0011001;
            4'h5: seg = 7'b0010010;
            4'h6: seg = 7'b0000010;
            4'h7: seg = 7'b1111000;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0010000;
            4'ha: seg = 7'b0001000;
            4'hb: seg = 7'b0000011;
            4'hc: seg = 7'b1000110;
            4'hd: seg = 7'b0100001;
            4'he: seg = 7'b0000110;
            default: seg = 7'b0001110;     // F
        endcase
        return seg;
    endfunction

    always_ff @(posedge clk) begin
        for (int k = 0; k < HEX_DIGITS; k++) begin
            if (!n_rst) begin
                o_hex[k] <= SEG_BLANK;
            end else begin
                o_hex[k] <= hex_font(i_value[4*k +: 4]);
            end
        end
    end

endmodule

// File: hdl/key_edge_detector.sv
/* Active-low push button in, one-cycle press pulse out three cycles after the key falls.
   No debounce; the key is assumed clean. */
`timescale 1ns/1ps

module key_edge_detector (
    input  logic clk,
    input  logic n_rst,
    input  logic i_key_n,
    output logic o_pulse
);

    logic [1:0] key_sync;
    logic       key_prev;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            key_sync <= 2'b11;                 // Released
            key_prev <= 1'b1;
            o_pulse  <= 1'b0;
        end else begin
            key_sync <= {key_sync[0], i_key_n};
            key_prev <= key_sync[1];
            o_pulse  <= key_prev & ~key_sync[1]; // Falling edge
        end
    end

    a_pulse_single: assert property (@(posedge clk) disable iff (!n_rst) o_pulse |=> !o_pulse);

endmodule

// File: hdl/wb_pkg.sv
/* Wishbone classic bus widths and types, byte addressed with one select bit per byte.
   SRAM occupies the Wishbone space from SRAM_BASE_ADDR upward. */
package wb_pkg;

    localparam int WB_DATA_WIDTH = 32;
    localparam int WB_ADDR_WIDTH = 32;
    localparam int WB_SEL_WIDTH  = WB_DATA_WIDTH / 8;

    typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;
    typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;
    typedef logic [WB_SEL_WIDTH-1:0]  wb_sel_t;

    localparam wb_addr_t SRAM_BASE_ADDR = 32'h0000_0000;

endpackage

// File: hdl/board_pkg.sv
/* Board-side constants for the 16-bit async SRAM, 7-segment display, keys and boot image.
   BOOT_HEX_FILE is relative to the simulation or synthesis working directory. */
package board_pkg;

    // External SRAM
    localparam int SRAM_ADDR_WIDTH = 20;   // Half-word address
    localparam int SRAM_DATA_WIDTH = 16;

    typedef logic [SRAM_ADDR_WIDTH-1:0] sram_addr_t;
    typedef logic [SRAM_DATA_WIDTH-1:0] sram_data_t;

    // Seven-segment digits are active low, segment g in bit 6
    typedef logic [6:0] seg7_t;
    localparam seg7_t SEG_BLANK  = 7'h7f;
    localparam int    HEX_DIGITS = 8;

    typedef logic [4:0] reg_idx_t;         // Retired destination register

    // Boot image copied into SRAM after reset
    localparam int    BOOT_WORDS    = 8;
    localparam string BOOT_HEX_FILE = "test/boot_image.hex";

endpackage
